/* verilog/harness_settings.svh */
// Pin-vector widths and per-pin indices for the board pin harness.
// Include wherever a pin index or a harness dimension is needed.
`ifndef HARNESS_SETTINGS_SVH
`define HARNESS_SETTINGS_SVH

// Widths of the three system pin vectors.
`define HARNESS_IN_PINS_W    8
`define HARNESS_OUT_PINS_W   16
`define HARNESS_INOUT_PINS_W 24

// Input-vector indices, device side toward the system.
`define IN_PIN_SER0_RX       0
`define IN_PIN_RS485_RX      1
`define IN_PIN_MICROSD_DAT0  2
`define IN_PIN_APPSPI_D1     3
`define IN_PIN_MB3           4
`define IN_PIN_MB8           5

// Output-vector indices, system toward the devices.
`define OUT_PIN_SER0_TX      0
`define OUT_PIN_RS485_TX     1
`define OUT_PIN_MICROSD_CMD  2
`define OUT_PIN_MICROSD_CLK  3
`define OUT_PIN_MICROSD_DAT3 4
`define OUT_PIN_APPSPI_CLK   5
`define OUT_PIN_APPSPI_D0    6
`define OUT_PIN_APPSPI_CS    7
`define OUT_PIN_MB4          8
`define OUT_PIN_MB7          9
`define OUT_PIN_MB10         10

// Inout-vector indices. I2C pins first.
`define INOUT_PIN_RPH_G0     0
`define INOUT_PIN_RPH_G1     1
`define INOUT_PIN_RPH_G2_SDA 2
`define INOUT_PIN_RPH_G3_SCL 3
`define INOUT_PIN_SCL1       4
`define INOUT_PIN_SDA1       5
// PMOD1 carries the SPI flash.
`define INOUT_PIN_PMOD1_1    6
`define INOUT_PIN_PMOD1_2    7
`define INOUT_PIN_PMOD1_3    8
`define INOUT_PIN_PMOD1_4    9
// Loopback pins.
`define INOUT_PIN_PMOD0_1    10
`define INOUT_PIN_PMOD0_8    11
`define INOUT_PIN_PMOD0_10   12
`define INOUT_PIN_AH_TMPIO0  13
`define INOUT_PIN_AH_TMPIO1  14
`define INOUT_PIN_AH_TMPIO8  15
`define INOUT_PIN_AH_TMPIO9  16
// Buses with board pull-ups and no device.
`define INOUT_PIN_SCL0       17
`define INOUT_PIN_SDA0       18
`define INOUT_PIN_MB5        19
`define INOUT_PIN_MB6        20

// Number of resolved I2C buses and of CHERI violation kinds.
`define HARNESS_I2C_BUSES    3
`define HARNESS_CHERI_KINDS  9

`endif

/* verilog/harness_pkg.sv */
// Shared types of the board pin harness.
// Modules refer to these by scoped name, harness_pkg::name.
`include "harness_settings.svh"

package harness_pkg;

  // Pins read by the system.
  typedef logic [`HARNESS_IN_PINS_W-1:0] in_pins_t;

  // Pins driven by the system.
  typedef logic [`HARNESS_OUT_PINS_W-1:0] out_pins_t;

  // Bidirectional pins; the same type serves values and enables.
  typedef logic [`HARNESS_INOUT_PINS_W-1:0] inout_pins_t;

  // One line per I2C bus.
  // Bus 0 is the HAT ID bus, bus 1 the HAT secondary bus, bus 2 is QWIIC1.
  typedef logic [`HARNESS_I2C_BUSES-1:0] i2c_lines_t;

  // One bit per CHERI violation kind.
  // Order is bounds, tag, seal, then the six permission kinds.
  typedef logic [`HARNESS_CHERI_KINDS-1:0] cheri_err_t;

endpackage

/* verilog/i2c_bus_resolver.sv */
// Open-drain resolution of I2C buses between controllers and device models.
// Instantiate once; each bit of every vector is one bus.
`timescale 1ns/1ns
`include "harness_settings.svh"

module i2c_bus_resolver #(
  parameter int NumBuses = `HARNESS_I2C_BUSES
) (
  // Controller drives and their enables.
  input  logic [NumBuses-1:0] scl_ctl_i,
  input  logic [NumBuses-1:0] scl_oe_i,
  input  logic [NumBuses-1:0] sda_ctl_i,
  input  logic [NumBuses-1:0] sda_oe_i,
  // Device drives, low to pull the line down.
  input  logic [NumBuses-1:0] scl_dev_i,
  input  logic [NumBuses-1:0] sda_dev_i,
  // Lines seen by the devices.
  output logic [NumBuses-1:0] scl_o,
  output logic [NumBuses-1:0] sda_o,
  // Lines seen by the controllers.
  output logic [NumBuses-1:0] scl_line_o,
  output logic [NumBuses-1:0] sda_line_o
);

  for (genvar b = 0; b < NumBuses; b++) begin : g_bus
    logic scl_drv;
    logic sda_drv;

    // A released line floats high through the pull-up.
    assign scl_drv = scl_oe_i[b] ? scl_ctl_i[b] : 1'b1;
    assign sda_drv = sda_oe_i[b] ? sda_ctl_i[b] : 1'b1;

    assign scl_o[b] = scl_drv;
    assign sda_o[b] = sda_drv;

    // Wired-AND of both sides.
    // The controller sees its own drive too, so it never reads
    // a mismatch as lost arbitration.
    assign scl_line_o[b] = scl_drv & scl_dev_i[b];
    assign sda_line_o[b] = sda_drv & sda_dev_i[b];
  end

endmodule

/* verilog/pin_router.sv */
// Decodes the system pin vectors onto device ports and rebuilds the return vectors.
// Covers SPI, UART, RS485 gating, I2C pin extraction and the loopback stage.
`timescale 1ns/1ns
`include "harness_settings.svh"

module pin_router (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // System pin vectors.
  input  harness_pkg::out_pins_t   out_pins_i,
  input  harness_pkg::inout_pins_t inout_pins_i,
  input  harness_pkg::inout_pins_t inout_pins_en_i,
  output harness_pkg::in_pins_t    in_pins_o,
  output harness_pkg::inout_pins_t inout_pins_o,
  // SPI devices; bit 0 flash, bit 1 microSD, bit 2 PMOD1.
  output logic [2:0]             spi_sck_o,
  output logic [2:0]             spi_cs_o,
  output logic [2:0]             spi_copi_o,
  input  logic [2:0]             spi_cipo_i,
  // System UART.
  output logic                   uart_tx_o,
  input  logic                   uart_rx_i,
  // RS485 transceiver.
  input  logic                   rs485_tx_en_i,
  input  logic                   rs485_rx_en_i,
  output logic                   rs485_line_o,
  input  logic                   rs485_line_i,
  // I2C controller side, toward the resolver.
  output harness_pkg::i2c_lines_t  i2c_scl_ctl_o,
  output harness_pkg::i2c_lines_t  i2c_scl_oe_o,
  output harness_pkg::i2c_lines_t  i2c_sda_ctl_o,
  output harness_pkg::i2c_lines_t  i2c_sda_oe_o,
  input  harness_pkg::i2c_lines_t  i2c_scl_line_i,
  input  harness_pkg::i2c_lines_t  i2c_sda_line_i
);

  logic [5:0] loopback_d;
  logic [5:0] loopback_q;

  // I2C pins, bus 0 HAT ID, bus 1 HAT secondary, bus 2 QWIIC1.
  assign i2c_scl_ctl_o = {inout_pins_i[`INOUT_PIN_SCL1],
                          inout_pins_i[`INOUT_PIN_RPH_G3_SCL],
                          inout_pins_i[`INOUT_PIN_RPH_G1]};
  assign i2c_scl_oe_o  = {inout_pins_en_i[`INOUT_PIN_SCL1],
                          inout_pins_en_i[`INOUT_PIN_RPH_G3_SCL],
                          inout_pins_en_i[`INOUT_PIN_RPH_G1]};
  assign i2c_sda_ctl_o = {inout_pins_i[`INOUT_PIN_SDA1],
                          inout_pins_i[`INOUT_PIN_RPH_G2_SDA],
                          inout_pins_i[`INOUT_PIN_RPH_G0]};
  assign i2c_sda_oe_o  = {inout_pins_en_i[`INOUT_PIN_SDA1],
                          inout_pins_en_i[`INOUT_PIN_RPH_G2_SDA],
                          inout_pins_en_i[`INOUT_PIN_RPH_G0]};

  // Application flash on dedicated outputs.
  assign spi_sck_o[0]  = out_pins_i[`OUT_PIN_APPSPI_CLK];
  assign spi_cs_o[0]   = out_pins_i[`OUT_PIN_APPSPI_CS];
  assign spi_copi_o[0] = out_pins_i[`OUT_PIN_APPSPI_D0];

  // microSD in SPI mode; DAT3 is chip select, CMD is COPI.
  assign spi_sck_o[1]  = out_pins_i[`OUT_PIN_MICROSD_CLK];
  assign spi_cs_o[1]   = out_pins_i[`OUT_PIN_MICROSD_DAT3];
  assign spi_copi_o[1] = out_pins_i[`OUT_PIN_MICROSD_CMD];

  // PMOD1 flash on inout pins.
  // An undriven pin idles high so chip select stays inactive.
  assign spi_cs_o[2]   = inout_pins_en_i[`INOUT_PIN_PMOD1_1] ?
                         inout_pins_i[`INOUT_PIN_PMOD1_1] : 1'b1;
  assign spi_copi_o[2] = inout_pins_en_i[`INOUT_PIN_PMOD1_2] ?
                         inout_pins_i[`INOUT_PIN_PMOD1_2] : 1'b1;
  assign spi_sck_o[2]  = inout_pins_en_i[`INOUT_PIN_PMOD1_4] ?
                         inout_pins_i[`INOUT_PIN_PMOD1_4] : 1'b1;

  assign uart_tx_o = out_pins_i[`OUT_PIN_SER0_TX];

  // Driver enable; an idle RS485 line sits at the mark level.
  assign rs485_line_o = rs485_tx_en_i ? out_pins_i[`OUT_PIN_RS485_TX] : 1'b1;

  // Loopback sources, in the order of the register bits.
  // PWM, UART, SPI and PWM loopbacks respectively.
  assign loopback_d = {inout_pins_i[`INOUT_PIN_AH_TMPIO8],
                       inout_pins_i[`INOUT_PIN_AH_TMPIO1],
                       out_pins_i[`OUT_PIN_MB10],
                       out_pins_i[`OUT_PIN_MB7],
                       out_pins_i[`OUT_PIN_MB4],
                       inout_pins_i[`INOUT_PIN_PMOD0_8]};

  // One register stage breaks the net-level loop from outputs back to inputs.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loopback_q <= '0;
    end else begin
      loopback_q <= loopback_d;
    end
  end

  // Inputs to the system; unrouted bits read 0.
  always_comb begin
    in_pins_o = '0;
    in_pins_o[`IN_PIN_SER0_RX]      = uart_rx_i;
    // Receiver disabled means the receive output reads low.
    in_pins_o[`IN_PIN_RS485_RX]     = rs485_rx_en_i & rs485_line_i;
    in_pins_o[`IN_PIN_MICROSD_DAT0] = spi_cipo_i[1];
    in_pins_o[`IN_PIN_APPSPI_D1]    = spi_cipo_i[0];
    // Loopback partners, MB7 to MB8 and MB4 to MB3.
    in_pins_o[`IN_PIN_MB8]          = loopback_q[2];
    in_pins_o[`IN_PIN_MB3]          = loopback_q[1];
  end

  // Inout values back to the system; unrouted bits read 0.
  always_comb begin
    inout_pins_o = '0;
    // Resolved I2C lines.
    inout_pins_o[`INOUT_PIN_RPH_G1]     = i2c_scl_line_i[0];
    inout_pins_o[`INOUT_PIN_RPH_G0]     = i2c_sda_line_i[0];
    inout_pins_o[`INOUT_PIN_RPH_G3_SCL] = i2c_scl_line_i[1];
    inout_pins_o[`INOUT_PIN_RPH_G2_SDA] = i2c_sda_line_i[1];
    inout_pins_o[`INOUT_PIN_SCL1]       = i2c_scl_line_i[2];
    inout_pins_o[`INOUT_PIN_SDA1]       = i2c_sda_line_i[2];
    // Pulled up on the board with nothing attached.
    inout_pins_o[`INOUT_PIN_SCL0]       = 1'b1;
    inout_pins_o[`INOUT_PIN_SDA0]       = 1'b1;
    inout_pins_o[`INOUT_PIN_MB5]        = 1'b1;
    inout_pins_o[`INOUT_PIN_MB6]        = 1'b1;
    // PMOD1 flash data out.
    inout_pins_o[`INOUT_PIN_PMOD1_3]    = spi_cipo_i[2];
    // Remaining loopback partners.
    inout_pins_o[`INOUT_PIN_AH_TMPIO9]  = loopback_q[5];
    inout_pins_o[`INOUT_PIN_AH_TMPIO0]  = loopback_q[4];
    inout_pins_o[`INOUT_PIN_PMOD0_1]    = loopback_q[3];
    inout_pins_o[`INOUT_PIN_PMOD0_10]   = loopback_q[0];
  end

endmodule

/* verilog/cheri_err_recorder.sv */
// Records the first occurrence of each CHERI violation kind.
// The error lines pulse repeatedly, so only new kinds raise cheri_new_o.
`timescale 1ns/1ns

module cheri_err_recorder (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Raw violation lines, one per kind.
  input  harness_pkg::cheri_err_t cheri_err_i,
  // Kinds seen since reset.
  output harness_pkg::cheri_err_t cheri_seen_o,
  // One-cycle pulse per newly seen kind.
  output harness_pkg::cheri_err_t cheri_new_o
);

  harness_pkg::cheri_err_t seen_q;
  harness_pkg::cheri_err_t new_q;
  harness_pkg::cheri_err_t first_hit;

  // Kinds active now that were not seen before.
  assign first_hit = cheri_err_i & ~seen_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_q <= '0;
      new_q  <= '0;
    end else begin
      // Sticky; bits only ever set.
      seen_q <= seen_q | cheri_err_i;
      // Cleared the next cycle since seen_q then covers the kind.
      new_q  <= first_hit;
    end
  end

  assign cheri_seen_o = seen_q;
  assign cheri_new_o  = new_q;

endmodule

/* verilog/board_harness.sv */
// Top level of the board pin harness.
// Sits between the system pin vectors and the external device models.
`timescale 1ns/1ns
`include "harness_settings.svh"

module board_harness (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // System pin vectors.
  input  harness_pkg::out_pins_t   out_pins_i,
  input  harness_pkg::inout_pins_t inout_pins_i,
  input  harness_pkg::inout_pins_t inout_pins_en_i,
  output harness_pkg::in_pins_t    in_pins_o,
  output harness_pkg::inout_pins_t inout_pins_o,
  // RS485 direction enables from the system.
  input  logic                     rs485_tx_en_i,
  input  logic                     rs485_rx_en_i,
  // CHERI violation lines and their record.
  input  harness_pkg::cheri_err_t  cheri_err_i,
  output harness_pkg::cheri_err_t  cheri_seen_o,
  output harness_pkg::cheri_err_t  cheri_new_o,
  // I2C device side.
  input  harness_pkg::i2c_lines_t  i2c_scl_dev_i,
  input  harness_pkg::i2c_lines_t  i2c_sda_dev_i,
  output harness_pkg::i2c_lines_t  i2c_scl_o,
  output harness_pkg::i2c_lines_t  i2c_sda_o,
  // SPI devices; bit 0 flash, bit 1 microSD, bit 2 PMOD1.
  output logic [2:0]               spi_sck_o,
  output logic [2:0]               spi_cs_o,
  output logic [2:0]               spi_copi_o,
  input  logic [2:0]               spi_cipo_i,
  // UART and RS485 device side.
  output logic                     uart_tx_o,
  input  logic                     uart_rx_i,
  output logic                     rs485_line_o,
  input  logic                     rs485_line_i
);

  // Controller drives and resolved lines between router and resolver.
  harness_pkg::i2c_lines_t scl_ctl;
  harness_pkg::i2c_lines_t scl_oe;
  harness_pkg::i2c_lines_t sda_ctl;
  harness_pkg::i2c_lines_t sda_oe;
  harness_pkg::i2c_lines_t scl_line;
  harness_pkg::i2c_lines_t sda_line;

  pin_router u_pin_router (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .out_pins_i      (out_pins_i),
    .inout_pins_i    (inout_pins_i),
    .inout_pins_en_i (inout_pins_en_i),
    .in_pins_o       (in_pins_o),
    .inout_pins_o    (inout_pins_o),
    .spi_sck_o       (spi_sck_o),
    .spi_cs_o        (spi_cs_o),
    .spi_copi_o      (spi_copi_o),
    .spi_cipo_i      (spi_cipo_i),
    .uart_tx_o       (uart_tx_o),
    .uart_rx_i       (uart_rx_i),
    .rs485_tx_en_i   (rs485_tx_en_i),
    .rs485_rx_en_i   (rs485_rx_en_i),
    .rs485_line_o    (rs485_line_o),
    .rs485_line_i    (rs485_line_i),
    .i2c_scl_ctl_o   (scl_ctl),
    .i2c_scl_oe_o    (scl_oe),
    .i2c_sda_ctl_o   (sda_ctl),
    .i2c_sda_oe_o    (sda_oe),
    .i2c_scl_line_i  (scl_line),
    .i2c_sda_line_i  (sda_line)
  );

  // All three buses resolve the same way.
  i2c_bus_resolver #(
    .NumBuses (`HARNESS_I2C_BUSES)
  ) u_i2c_bus_resolver (
    .scl_ctl_i  (scl_ctl),
    .scl_oe_i   (scl_oe),
    .sda_ctl_i  (sda_ctl),
    .sda_oe_i   (sda_oe),
    .scl_dev_i  (i2c_scl_dev_i),
    .sda_dev_i  (i2c_sda_dev_i),
    .scl_o      (i2c_scl_o),
    .sda_o      (i2c_sda_o),
    .scl_line_o (scl_line),
    .sda_line_o (sda_line)
  );

  cheri_err_recorder u_cheri_err_recorder (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cheri_err_i  (cheri_err_i),
    .cheri_seen_o (cheri_seen_o),
    .cheri_new_o  (cheri_new_o)
  );

endmodule

/* verification/tb_checks.svh */
// Reference model and typed compare tasks for the board pin harness testbench.
// Included inside the testbench module, after test_name and abort_run.
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  // A pin whose driver is off reads high through its pull-up.
  function automatic logic pulled_high(input logic val, input logic en);
    return en ? val : 1'b1;
  endfunction

  // SCL as the devices see it, bus 0 HAT ID, bus 1 HAT secondary, bus 2 QWIIC1.
  function automatic harness_pkg::i2c_lines_t ref_scl_dev(
      input harness_pkg::inout_pins_t val, input harness_pkg::inout_pins_t en);
    harness_pkg::i2c_lines_t r;
    r[0] = pulled_high(val[`INOUT_PIN_RPH_G1], en[`INOUT_PIN_RPH_G1]);
    r[1] = pulled_high(val[`INOUT_PIN_RPH_G3_SCL], en[`INOUT_PIN_RPH_G3_SCL]);
    r[2] = pulled_high(val[`INOUT_PIN_SCL1], en[`INOUT_PIN_SCL1]);
    return r;
  endfunction

  // SDA as the devices see it.
  function automatic harness_pkg::i2c_lines_t ref_sda_dev(
      input harness_pkg::inout_pins_t val, input harness_pkg::inout_pins_t en);
    harness_pkg::i2c_lines_t r;
    r[0] = pulled_high(val[`INOUT_PIN_RPH_G0], en[`INOUT_PIN_RPH_G0]);
    r[1] = pulled_high(val[`INOUT_PIN_RPH_G2_SDA], en[`INOUT_PIN_RPH_G2_SDA]);
    r[2] = pulled_high(val[`INOUT_PIN_SDA1], en[`INOUT_PIN_SDA1]);
    return r;
  endfunction

  // System inputs; loopback partners take the source value of the last edge.
  function automatic harness_pkg::in_pins_t ref_in_pins(
      input logic uart_rx, input logic rx_en, input logic line,
      input logic [2:0] cipo, input harness_pkg::out_pins_t last_out);
    harness_pkg::in_pins_t r;
    r = '0;
    r[`IN_PIN_SER0_RX]      = uart_rx;
    r[`IN_PIN_RS485_RX]     = rx_en ? line : 1'b0;
    r[`IN_PIN_MICROSD_DAT0] = cipo[1];
    r[`IN_PIN_APPSPI_D1]    = cipo[0];
    r[`IN_PIN_MB8]          = last_out[`OUT_PIN_MB7];
    r[`IN_PIN_MB3]          = last_out[`OUT_PIN_MB4];
    return r;
  endfunction

  // Inout values returned to the system.
  function automatic harness_pkg::inout_pins_t ref_inout_pins(
      input harness_pkg::inout_pins_t val, input harness_pkg::inout_pins_t en,
      input harness_pkg::i2c_lines_t scl_dev, input harness_pkg::i2c_lines_t sda_dev,
      input logic [2:0] cipo, input harness_pkg::out_pins_t last_out,
      input harness_pkg::inout_pins_t last_inout);
    harness_pkg::i2c_lines_t scl;
    harness_pkg::i2c_lines_t sda;
    harness_pkg::inout_pins_t r;
    // Wired-AND of the controller side and the device side.
    scl = ref_scl_dev(val, en) & scl_dev;
    sda = ref_sda_dev(val, en) & sda_dev;
    r = '0;
    r[`INOUT_PIN_RPH_G1]     = scl[0];
    r[`INOUT_PIN_RPH_G0]     = sda[0];
    r[`INOUT_PIN_RPH_G3_SCL] = scl[1];
    r[`INOUT_PIN_RPH_G2_SDA] = sda[1];
    r[`INOUT_PIN_SCL1]       = scl[2];
    r[`INOUT_PIN_SDA1]       = sda[2];
    // Empty buses idle high.
    r[`INOUT_PIN_SCL0]       = 1'b1;
    r[`INOUT_PIN_SDA0]       = 1'b1;
    r[`INOUT_PIN_MB5]        = 1'b1;
    r[`INOUT_PIN_MB6]        = 1'b1;
    r[`INOUT_PIN_PMOD1_3]    = cipo[2];
    r[`INOUT_PIN_AH_TMPIO9]  = last_inout[`INOUT_PIN_AH_TMPIO8];
    r[`INOUT_PIN_AH_TMPIO0]  = last_inout[`INOUT_PIN_AH_TMPIO1];
    r[`INOUT_PIN_PMOD0_1]    = last_out[`OUT_PIN_MB10];
    r[`INOUT_PIN_PMOD0_10]   = last_inout[`INOUT_PIN_PMOD0_8];
    return r;
  endfunction

  task automatic check_in_pins(input string what, input harness_pkg::in_pins_t exp,
                               input harness_pkg::in_pins_t act);
    if (act !== exp) begin
      abort_run($sformatf("Error [%s] %s: expected %h, actual %h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_inout_pins(input string what, input harness_pkg::inout_pins_t exp,
                                  input harness_pkg::inout_pins_t act);
    if (act !== exp) begin
      abort_run($sformatf("Error [%s] %s: expected %h, actual %h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_i2c(input string what, input harness_pkg::i2c_lines_t exp,
                           input harness_pkg::i2c_lines_t act);
    if (act !== exp) begin
      abort_run($sformatf("Error [%s] %s: expected %b, actual %b",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_cheri(input string what, input harness_pkg::cheri_err_t exp,
                             input harness_pkg::cheri_err_t act);
    if (act !== exp) begin
      abort_run($sformatf("Error [%s] %s: expected %b, actual %b",
                          test_name, what, exp, act));
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("Error [%s] %s: expected %b, actual %b",
                          test_name, what, exp, act));
    end
  endtask

`endif

/* verification/tb_board_harness.sv */
// Testbench for the board pin harness top level.
// Drives random pin, device and CHERI stimulus and checks every output each cycle.
`timescale 1ns/1ns
`include "harness_settings.svh"

module tb_board_harness;

  // Sum of all phase lengths, rounded up; the timeout is four times that.
  localparam int planned_cycles = 600;
  localparam int timeout_cycles = 4 * planned_cycles;

  logic                     clk_i;
  logic                     rst_ni;
  harness_pkg::out_pins_t   out_pins_i;
  harness_pkg::inout_pins_t inout_pins_i;
  harness_pkg::inout_pins_t inout_pins_en_i;
  harness_pkg::in_pins_t    in_pins_o;
  harness_pkg::inout_pins_t inout_pins_o;
  logic                     rs485_tx_en_i;
  logic                     rs485_rx_en_i;
  harness_pkg::cheri_err_t  cheri_err_i;
  harness_pkg::cheri_err_t  cheri_seen_o;
  harness_pkg::cheri_err_t  cheri_new_o;
  harness_pkg::i2c_lines_t  i2c_scl_dev_i;
  harness_pkg::i2c_lines_t  i2c_sda_dev_i;
  harness_pkg::i2c_lines_t  i2c_scl_o;
  harness_pkg::i2c_lines_t  i2c_sda_o;
  logic [2:0]               spi_sck_o;
  logic [2:0]               spi_cs_o;
  logic [2:0]               spi_copi_o;
  logic [2:0]               spi_cipo_i;
  logic                     uart_tx_o;
  logic                     uart_rx_i;
  logic                     rs485_line_o;
  logic                     rs485_line_i;

  int          seed;
  int          cycle_count = 0;
  string       test_name;
  logic [31:0] rnd;

  // Model state: loopback sources at the last edge and the CHERI record.
  harness_pkg::out_pins_t   last_out = '0;
  harness_pkg::inout_pins_t last_inout = '0;
  harness_pkg::cheri_err_t  seen_m = '0;
  harness_pkg::cheri_err_t  new_m = '0;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on the first failure.");
  endtask

  `include "tb_checks.svh"

  board_harness i_board_harness (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Runaway guard.
  always @(posedge clk_i) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      abort_run($sformatf("Timeout: the run did not end within %0d cycles.", timeout_cycles));
    end
  end

  // Compares before the edge updates the model, like a flop would.
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      last_out   = '0;
      last_inout = '0;
      seen_m     = '0;
      new_m      = '0;
    end else begin
      check_i2c("scl to devices", ref_scl_dev(inout_pins_i, inout_pins_en_i), i2c_scl_o);
      check_i2c("sda to devices", ref_sda_dev(inout_pins_i, inout_pins_en_i), i2c_sda_o);
      check_in_pins("in_pins_o", ref_in_pins(uart_rx_i, rs485_rx_en_i, rs485_line_i,
                                             spi_cipo_i, last_out), in_pins_o);
      // Also covers the fixed and pulled-up pins.
      check_inout_pins("inout_pins_o", ref_inout_pins(inout_pins_i, inout_pins_en_i,
                       i2c_scl_dev_i, i2c_sda_dev_i, spi_cipo_i, last_out, last_inout),
                       inout_pins_o);
      check_bit("flash sck", out_pins_i[`OUT_PIN_APPSPI_CLK], spi_sck_o[0]);
      check_bit("flash cs", out_pins_i[`OUT_PIN_APPSPI_CS], spi_cs_o[0]);
      check_bit("flash copi", out_pins_i[`OUT_PIN_APPSPI_D0], spi_copi_o[0]);
      check_bit("microsd sck", out_pins_i[`OUT_PIN_MICROSD_CLK], spi_sck_o[1]);
      check_bit("microsd cs", out_pins_i[`OUT_PIN_MICROSD_DAT3], spi_cs_o[1]);
      check_bit("microsd copi", out_pins_i[`OUT_PIN_MICROSD_CMD], spi_copi_o[1]);
      check_bit("pmod1 cs", pulled_high(inout_pins_i[`INOUT_PIN_PMOD1_1],
                inout_pins_en_i[`INOUT_PIN_PMOD1_1]), spi_cs_o[2]);
      check_bit("pmod1 copi", pulled_high(inout_pins_i[`INOUT_PIN_PMOD1_2],
                inout_pins_en_i[`INOUT_PIN_PMOD1_2]), spi_copi_o[2]);
      check_bit("pmod1 sck", pulled_high(inout_pins_i[`INOUT_PIN_PMOD1_4],
                inout_pins_en_i[`INOUT_PIN_PMOD1_4]), spi_sck_o[2]);
      check_bit("uart tx", out_pins_i[`OUT_PIN_SER0_TX], uart_tx_o);
      check_bit("rs485 line", pulled_high(out_pins_i[`OUT_PIN_RS485_TX], rs485_tx_en_i),
                rs485_line_o);
      check_cheri("cheri_seen_o", seen_m, cheri_seen_o);
      check_cheri("cheri_new_o", new_m, cheri_new_o);
      new_m      = cheri_err_i & ~seen_m;
      seen_m     = seen_m | cheri_err_i;
      last_out   = out_pins_i;
      last_inout = inout_pins_i;
    end
  end

  task automatic randomize_i2c();
    rnd = $random(seed);
    inout_pins_i = rnd[`HARNESS_INOUT_PINS_W-1:0];
    rnd = $random(seed);
    inout_pins_en_i = rnd[`HARNESS_INOUT_PINS_W-1:0];
    rnd = $random(seed);
    i2c_scl_dev_i = rnd[2:0];
    i2c_sda_dev_i = rnd[5:3];
  endtask

  task automatic randomize_routing();
    rnd = $random(seed);
    out_pins_i = rnd[`HARNESS_OUT_PINS_W-1:0];
    rnd = $random(seed);
    inout_pins_en_i = rnd[`HARNESS_INOUT_PINS_W-1:0];
    rnd = $random(seed);
    inout_pins_i = rnd[`HARNESS_INOUT_PINS_W-1:0];
    rs485_tx_en_i = rnd[24];
    rs485_rx_en_i = rnd[25];
    uart_rx_i = rnd[26];
    rs485_line_i = rnd[27];
    spi_cipo_i = rnd[30:28];
  endtask

  task automatic randomize_loopback();
    rnd = $random(seed);
    out_pins_i = rnd[`HARNESS_OUT_PINS_W-1:0];
    rnd = $random(seed);
    inout_pins_i = rnd[`HARNESS_INOUT_PINS_W-1:0];
  endtask

  // Mostly one kind at a time, often repeated, so new kinds stay visible.
  task automatic randomize_cheri();
    int kind;
    rnd = $random(seed);
    kind = int'(rnd[15:8]) % `HARNESS_CHERI_KINDS;
    if (rnd[1:0] == 2'd0) begin
      cheri_err_i = cheri_err_i;
    end else if (rnd[3:2] == 2'd0) begin
      cheri_err_i = '0;
    end else begin
      cheri_err_i = harness_pkg::cheri_err_t'(1) << kind;
    end
  endtask

  task automatic run_phase(input string name, input int cycles, input bit do_i2c,
                           input bit do_route, input bit do_loop, input bit do_cheri);
    repeat (cycles) begin
      @(negedge clk_i);
      test_name = name;
      if (do_i2c) randomize_i2c();
      if (do_route) randomize_routing();
      if (do_loop) randomize_loopback();
      if (do_cheri) randomize_cheri();
    end
  endtask

  initial begin
    seed = 32'h248b_30a1;
    test_name = "reset";
    rst_ni = 1'b0;
    out_pins_i = '0;
    inout_pins_i = '0;
    inout_pins_en_i = '0;
    rs485_tx_en_i = 1'b0;
    rs485_rx_en_i = 1'b0;
    cheri_err_i = '0;
    i2c_scl_dev_i = '1;
    i2c_sda_dev_i = '1;
    spi_cipo_i = '0;
    uart_rx_i = 1'b1;
    rs485_line_i = 1'b1;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    run_phase("after_reset", 4, 1'b0, 1'b0, 1'b0, 1'b0);
    run_phase("i2c_wired_and", 150, 1'b1, 1'b0, 1'b0, 1'b0);
    run_phase("spi_uart_rs485", 150, 1'b0, 1'b1, 1'b0, 1'b0);
    run_phase("loopback_delay", 100, 1'b0, 1'b0, 1'b1, 1'b0);
    // Fresh reset so the CHERI mask starts empty.
    test_name = "cheri_reset";
    rst_ni = 1'b0;
    cheri_err_i = '0;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    run_phase("cheri_record", 150, 1'b0, 1'b0, 1'b0, 1'b1);
    run_phase("mixed", 40, 1'b1, 1'b1, 1'b1, 1'b1);
    @(negedge clk_i);
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* src.f */
+incdir+verilog
+incdir+verification
verilog/harness_pkg.sv
verilog/i2c_bus_resolver.sv
verilog/pin_router.sv
verilog/cheri_err_recorder.sv
verilog/board_harness.sv
verification/tb_board_harness.sv

/* Makefile */
# Verilator build and run of the board pin harness testbench.
# The run fails with a nonzero exit status when a check fails.

BUILD_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ns -j 0 -f src.f \
		--top-module tb_board_harness -Mdir $(BUILD_DIR) -o tb_board_harness
	./$(BUILD_DIR)/tb_board_harness

clean:
	rm -rf $(BUILD_DIR)
